// File: hdl/eeprom_consts.svh
`ifndef EEPROM_CONSTS_SVH
`define EEPROM_CONSTS_SVH

// system clocks per SCL half period
`define EEPROM_SCL_HALF 4

// fixed upper nibble of the control byte
`define EEPROM_DEV_CODE 4'b1010

`define EEPROM_ADDR_W 11   // 2K x 8 array
`define EEPROM_DATA_W 8

`endif

// File: hdl/eeprom_pkg.sv
`default_nettype none
`include "eeprom_consts.svh"

package eeprom_pkg;

    typedef logic [`EEPROM_ADDR_W-1:0] eeprom_addr_t;
    typedef logic [`EEPROM_DATA_W-1:0] eeprom_byte_t;

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_W,
        ADDR,
        DATA_W,
        RESTART,
        CTRL_R,
        DATA_R,
        STOP,
        RETRY_STOP,
        DONE
    } ctrl_state_t;

    typedef enum logic {
        COND_START,
        COND_STOP
    } cond_kind_t;

    typedef struct packed {
        logic         cyc;
        logic         stb;
        logic         we;
        eeprom_addr_t adr;
        eeprom_byte_t dat;
    } wb_req_t;

    typedef struct packed {
        logic         ack;
        eeprom_byte_t dat;  // read data, valid with ack
    } wb_rsp_t;

endpackage

`default_nettype wire

// File: hdl/i2c_scl_gen.sv
`default_nettype none
`include "eeprom_consts.svh"

module i2c_scl_gen (
    input  logic CLK,
    input  logic RESET,
    input  logic run,
    output logic scl,
    output logic low_mid,
    output logic high_mid
);
    localparam int HALF = `EEPROM_SCL_HALF;
    localparam int CW = $clog2(HALF);
    localparam logic [CW-1:0] LAST = CW'(HALF - 1);
    localparam logic [CW-1:0] MID = CW'(HALF / 2 - 1);

    logic [CW-1:0] cnt;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            cnt <= '0;
            scl <= 1'b1;
        end
        else if (!run)
        begin
            cnt <= '0;
            scl <= 1'b1;  // parked high while the bus is idle
        end
        else if (cnt == LAST)
        begin
            cnt <= '0;
            scl <= ~scl;
        end
        else
        begin
            cnt <= cnt + CW'(1);
        end
    end

    // one clock wide, in the middle of each phase
    assign low_mid  = run && !scl && (cnt == MID);
    assign high_mid = run && scl && (cnt == MID);

endmodule

`default_nettype wire

// File: hdl/i2c_cond_gen.sv
`default_nettype none

module i2c_cond_gen (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   cond_go,
    input  eeprom_pkg::cond_kind_t cond_kind,
    input  logic                   scl,
    input  logic                   low_mid,
    input  logic                   high_mid,
    output logic                   sda_pull,
    output logic                   cond_done
);
    typedef enum logic [1:0] {
        C_IDLE,
        C_PRE,
        C_FLIP,
        C_HOLD
    } step_t;

    step_t                  step;
    eeprom_pkg::cond_kind_t kind;

    always_ff @(posedge CLK)
    begin
        if (cond_go)
            kind <= cond_kind;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            step      <= C_IDLE;
            sda_pull  <= 1'b0;
            cond_done <= 1'b0;
        end
        else
        begin
            cond_done <= 1'b0;
            if (cond_go)
            begin
                step <= C_PRE;  // a new request overrides a pending hold
            end
            else
            begin
                case (step)
                    C_PRE:
                        if (low_mid)
                        begin
                            sda_pull <= (kind == eeprom_pkg::COND_STOP);
                            step     <= C_FLIP;
                        end
                    C_FLIP:
                        if (high_mid && scl)
                        begin
                            // edge on SDA with SCL high is the condition itself
                            sda_pull  <= (kind == eeprom_pkg::COND_START);
                            cond_done <= 1'b1;
                            step      <= C_HOLD;
                        end
                    C_HOLD:
                        if (low_mid)
                        begin
                            sda_pull <= 1'b0;  // next block takes the line here
                            step     <= C_IDLE;
                        end
                    default:
                        step <= C_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/i2c_byte_tx.sv
`default_nettype none

module i2c_byte_tx (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     tx_go,
    input  eeprom_pkg::eeprom_byte_t tx_byte,
    input  logic                     low_mid,
    input  logic                     high_mid,
    input  logic                     sda_in,
    output logic                     sda_pull,
    output logic                     tx_done,
    output logic                     tx_nack
);
    eeprom_pkg::eeprom_byte_t shreg;
    logic [3:0]               bit_cnt;  // 0..7 data, 8 release, 9 ack clock
    logic                     busy;

    always_ff @(posedge CLK)
    begin
        if (tx_go)
            shreg <= tx_byte;
        else if (busy && low_mid && bit_cnt < 4'd8)
            shreg <= {shreg[6:0], 1'b0};
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy     <= 1'b0;
            bit_cnt  <= '0;
            sda_pull <= 1'b0;
            tx_done  <= 1'b0;
            tx_nack  <= 1'b0;
        end
        else
        begin
            tx_done <= 1'b0;
            if (tx_go)
            begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end
            else if (busy)
            begin
                if (low_mid && bit_cnt < 4'd8)
                begin
                    sda_pull <= ~shreg[7];  // MSB first
                    bit_cnt  <= bit_cnt + 4'd1;
                end
                else if (low_mid && bit_cnt == 4'd8)
                begin
                    sda_pull <= 1'b0;  // hand the line to the slave
                    bit_cnt  <= 4'd9;
                end
                else if (high_mid && bit_cnt == 4'd9)
                begin
                    tx_nack <= sda_in;
                    tx_done <= 1'b1;
                    busy    <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/i2c_byte_rx.sv
`default_nettype none

module i2c_byte_rx (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     rx_go,
    input  logic                     low_mid,
    input  logic                     high_mid,
    input  logic                     sda_in,
    output logic                     sda_pull,
    output logic                     rx_done,
    output eeprom_pkg::eeprom_byte_t rx_byte
);
    logic [3:0] bit_cnt;
    logic       busy;
    logic       armed;  // a low phase has passed since the last sample

    // data bits and the closing NACK all leave the line released
    assign sda_pull = 1'b0;

    always_ff @(posedge CLK)
    begin
        if (busy && armed && high_mid && bit_cnt < 4'd8)
            rx_byte <= {rx_byte[6:0], sda_in};
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            armed   <= 1'b0;
            bit_cnt <= '0;
            rx_done <= 1'b0;
        end
        else
        begin
            rx_done <= 1'b0;
            if (rx_go)
            begin
                busy    <= 1'b1;
                armed   <= 1'b0;
                bit_cnt <= '0;
            end
            else if (busy)
            begin
                if (low_mid)
                    armed <= 1'b1;
                else if (high_mid && armed)
                begin
                    armed <= 1'b0;
                    if (bit_cnt < 4'd8)
                        bit_cnt <= bit_cnt + 4'd1;
                    else
                    begin
                        rx_done <= 1'b1;  // ninth clock, NACK seen by slave
                        busy    <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/eeprom_ctrl.sv
`default_nettype none
`include "eeprom_consts.svh"

module eeprom_ctrl (
    input  logic                     CLK,
    input  logic                     RESET,
    input  eeprom_pkg::wb_req_t      wb_req,
    output eeprom_pkg::wb_rsp_t      wb_rsp,
    output logic                     run,
    output logic                     cond_go,
    output eeprom_pkg::cond_kind_t   cond_kind,
    input  logic                     cond_done,
    output logic                     tx_go,
    output eeprom_pkg::eeprom_byte_t tx_byte,
    input  logic                     tx_done,
    input  logic                     tx_nack,
    output logic                     rx_go,
    input  logic                     rx_done,
    input  eeprom_pkg::eeprom_byte_t rx_byte
);
    eeprom_pkg::ctrl_state_t  state;
    eeprom_pkg::eeprom_addr_t req_adr;
    eeprom_pkg::eeprom_byte_t req_dat;
    logic                     req_we;
    logic                     ack;
    eeprom_pkg::eeprom_byte_t rd_dat;
    logic                     new_req;
    eeprom_pkg::eeprom_byte_t ctrl_w;
    eeprom_pkg::eeprom_byte_t ctrl_r;

    // ack still high means the master has not yet seen the end of its cycle
    assign new_req = wb_req.cyc && wb_req.stb && !ack;

    // block select comes from the top address bits
    assign ctrl_w = {`EEPROM_DEV_CODE, req_adr[`EEPROM_ADDR_W-1:8], 1'b0};
    assign ctrl_r = {`EEPROM_DEV_CODE, req_adr[`EEPROM_ADDR_W-1:8], 1'b1};

    assign wb_rsp.ack = ack;
    assign wb_rsp.dat = rd_dat;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= eeprom_pkg::IDLE;
            run       <= 1'b0;
            ack       <= 1'b0;
            cond_go   <= 1'b0;
            cond_kind <= eeprom_pkg::COND_START;
            tx_go     <= 1'b0;
            tx_byte   <= '0;
            rx_go     <= 1'b0;
        end
        else
        begin
            cond_go <= 1'b0;
            tx_go   <= 1'b0;
            rx_go   <= 1'b0;
            ack     <= 1'b0;
            case (state)
                eeprom_pkg::IDLE:
                    if (new_req)
                    begin
                        req_adr   <= wb_req.adr;
                        req_dat   <= wb_req.dat;
                        req_we    <= wb_req.we;
                        run       <= 1'b1;
                        cond_go   <= 1'b1;
                        cond_kind <= eeprom_pkg::COND_START;
                        state     <= eeprom_pkg::START;
                    end
                eeprom_pkg::START:
                    if (cond_done)
                    begin
                        tx_go   <= 1'b1;
                        tx_byte <= ctrl_w;
                        state   <= eeprom_pkg::CTRL_W;
                    end
                eeprom_pkg::CTRL_W:
                    if (tx_done && tx_nack)
                    begin
                        cond_go   <= 1'b1;  // still busy writing, poll again
                        cond_kind <= eeprom_pkg::COND_STOP;
                        state     <= eeprom_pkg::RETRY_STOP;
                    end
                    else if (tx_done)
                    begin
                        tx_go   <= 1'b1;
                        tx_byte <= req_adr[7:0];
                        state   <= eeprom_pkg::ADDR;
                    end
                eeprom_pkg::ADDR:
                    if (tx_done && req_we)
                    begin
                        tx_go   <= 1'b1;
                        tx_byte <= req_dat;
                        state   <= eeprom_pkg::DATA_W;
                    end
                    else if (tx_done)
                    begin
                        cond_go   <= 1'b1;  // random read, dummy write done
                        cond_kind <= eeprom_pkg::COND_START;
                        state     <= eeprom_pkg::RESTART;
                    end
                eeprom_pkg::DATA_W:
                    if (tx_done)
                    begin
                        cond_go   <= 1'b1;
                        cond_kind <= eeprom_pkg::COND_STOP;
                        state     <= eeprom_pkg::STOP;
                    end
                eeprom_pkg::RESTART:
                    if (cond_done)
                    begin
                        tx_go   <= 1'b1;
                        tx_byte <= ctrl_r;
                        state   <= eeprom_pkg::CTRL_R;
                    end
                eeprom_pkg::CTRL_R:
                    if (tx_done && tx_nack)
                    begin
                        cond_go   <= 1'b1;
                        cond_kind <= eeprom_pkg::COND_STOP;
                        state     <= eeprom_pkg::RETRY_STOP;
                    end
                    else if (tx_done)
                    begin
                        rx_go <= 1'b1;
                        state <= eeprom_pkg::DATA_R;
                    end
                eeprom_pkg::DATA_R:
                    if (rx_done)
                    begin
                        cond_go   <= 1'b1;
                        cond_kind <= eeprom_pkg::COND_STOP;
                        state     <= eeprom_pkg::STOP;
                    end
                eeprom_pkg::STOP:
                    if (cond_done)
                    begin
                        run   <= 1'b0;  // SCL is high here, parks without a glitch
                        state <= eeprom_pkg::DONE;
                    end
                eeprom_pkg::RETRY_STOP:
                    if (cond_done)
                    begin
                        cond_go   <= 1'b1;
                        cond_kind <= eeprom_pkg::COND_START;
                        state     <= eeprom_pkg::START;
                    end
                eeprom_pkg::DONE:
                begin
                    ack <= 1'b1;
                    if (!req_we)
                        rd_dat <= rx_byte;
                    state <= eeprom_pkg::IDLE;
                end
                default:
                    state <= eeprom_pkg::IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/eeprom_i2c_top.sv
`default_nettype none

module eeprom_i2c_top (
    input  logic                CLK,
    input  logic                RESET,
    input  eeprom_pkg::wb_req_t wb_req,
    output eeprom_pkg::wb_rsp_t wb_rsp,
    output logic                scl,
    output logic                sda_pull,
    input  logic                sda_in
);
    logic                     run;
    logic                     low_mid;
    logic                     high_mid;
    logic                     cond_go;
    eeprom_pkg::cond_kind_t   cond_kind;
    logic                     cond_done;
    logic                     cond_pull;
    logic                     tx_go;
    eeprom_pkg::eeprom_byte_t tx_byte;
    logic                     tx_done;
    logic                     tx_nack;
    logic                     tx_pull;
    logic                     rx_go;
    logic                     rx_done;
    eeprom_pkg::eeprom_byte_t rx_byte;
    logic                     rx_pull;

    // open drain, any block may pull the line low
    assign sda_pull = cond_pull | tx_pull | rx_pull;

    eeprom_ctrl ctrl_i (
        .CLK(CLK), .RESET(RESET),
        .wb_req(wb_req), .wb_rsp(wb_rsp), .run(run),
        .cond_go(cond_go), .cond_kind(cond_kind), .cond_done(cond_done),
        .tx_go(tx_go), .tx_byte(tx_byte), .tx_done(tx_done), .tx_nack(tx_nack),
        .rx_go(rx_go), .rx_done(rx_done), .rx_byte(rx_byte)
    );

    i2c_scl_gen scl_gen_i (
        .CLK(CLK), .RESET(RESET), .run(run),
        .scl(scl), .low_mid(low_mid), .high_mid(high_mid)
    );

    i2c_cond_gen cond_gen_i (
        .CLK(CLK), .RESET(RESET), .cond_go(cond_go), .cond_kind(cond_kind),
        .scl(scl), .low_mid(low_mid), .high_mid(high_mid),
        .sda_pull(cond_pull), .cond_done(cond_done)
    );

    i2c_byte_tx byte_tx_i (
        .CLK(CLK), .RESET(RESET), .tx_go(tx_go), .tx_byte(tx_byte),
        .low_mid(low_mid), .high_mid(high_mid), .sda_in(sda_in),
        .sda_pull(tx_pull), .tx_done(tx_done), .tx_nack(tx_nack)
    );

    i2c_byte_rx byte_rx_i (
        .CLK(CLK), .RESET(RESET), .rx_go(rx_go),
        .low_mid(low_mid), .high_mid(high_mid), .sda_in(sda_in),
        .sda_pull(rx_pull), .rx_done(rx_done), .rx_byte(rx_byte)
    );

endmodule

`default_nettype wire

// File: tb/eeprom_model.sv
`default_nettype none

module eeprom_model #(
    parameter int TWR = 300
) (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    output logic sda_pull,
    output int   errors
);
    typedef enum logic [1:0] {M_IDLE, M_RX, M_TX} mode_t;
    typedef enum logic [1:0] {S_CTRL, S_ADDR, S_DATA, S_DONE} stage_t;

    logic [7:0]  mem [0:2047];
    mode_t       mode;
    stage_t      stage;
    logic [3:0]  bcnt;  // 8 after the last data bit, 9 in the ack clock
    logic [7:0]  sh;
    logic [7:0]  tx_sh;
    logic        to_tx;
    logic [2:0]  blk;
    logic [10:0] ptr;
    logic        wr_pend;  // written into the array only at stop
    logic [10:0] wr_adr;
    logic [7:0]  wr_dat;
    int          busy;
    logic        prev_scl;
    logic        prev_sda;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hFF;
    end

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            mode     <= M_IDLE;
            stage    <= S_CTRL;
            bcnt     <= '0;
            sda_pull <= 1'b0;
            to_tx    <= 1'b0;
            wr_pend  <= 1'b0;
            busy     <= 0;
            errors   <= 0;
            prev_scl <= 1'b1;
            prev_sda <= 1'b1;
        end
        else
        begin
            prev_scl <= scl;
            prev_sda <= sda;
            if (busy > 0)
                busy <= busy - 1;
            if (scl && prev_scl && prev_sda && !sda)
            begin
                mode     <= M_RX;  // start or repeated start
                stage    <= S_CTRL;
                bcnt     <= '0;
                wr_pend  <= 1'b0;
                sda_pull <= 1'b0;
            end
            else if (scl && prev_scl && !prev_sda && sda)
            begin
                // the stop's own SCL rise has already counted one bit
                assert (mode == M_IDLE || bcnt <= 4'd1)
                else
                begin
                    errors <= errors + 1;
                    $display("model error: stop condition in the middle of a byte");
                end
                if (wr_pend)
                begin
                    mem[wr_adr] <= wr_dat;
                    busy        <= TWR;  // internal write cycle
                end
                wr_pend  <= 1'b0;
                mode     <= M_IDLE;
                sda_pull <= 1'b0;
            end
            else if (scl && !prev_scl)
            begin
                if (mode == M_RX && bcnt < 4'd8)
                begin
                    sh   <= {sh[6:0], sda};
                    bcnt <= bcnt + 4'd1;
                end
                else if (mode == M_TX && bcnt < 4'd8)
                begin
                    tx_sh <= {tx_sh[6:0], 1'b0};
                    bcnt  <= bcnt + 4'd1;
                end
                else if (mode == M_TX)
                begin
                    assert (sda)
                    else
                    begin
                        errors <= errors + 1;
                        $display("model error: master acknowledged the read byte");
                    end
                    mode <= M_IDLE;
                end
            end
            else if (!scl && prev_scl)
            begin
                if (mode == M_RX && bcnt == 4'd8)
                begin
                    bcnt <= 4'd9;
                    case (stage)
                        S_CTRL:
                            if (sh[7:4] == 4'b1010 && busy == 0)
                            begin
                                sda_pull <= 1'b1;
                                blk      <= sh[3:1];
                                to_tx    <= sh[0];
                                ptr      <= {sh[3:1], ptr[7:0]};
                                tx_sh    <= mem[{sh[3:1], ptr[7:0]}];
                                stage    <= S_ADDR;
                            end
                            else
                                mode <= M_IDLE;  // no ack while busy
                        S_ADDR:
                        begin
                            sda_pull <= 1'b1;
                            ptr      <= {blk, sh};
                            stage    <= S_DATA;
                        end
                        S_DATA:
                        begin
                            sda_pull <= 1'b1;
                            wr_pend  <= 1'b1;
                            wr_adr   <= ptr;
                            wr_dat   <= sh;
                            stage    <= S_DONE;
                        end
                        default:
                        begin
                            assert (1'b0)
                            else
                            begin
                                errors <= errors + 1;
                                $display("model error: more than one data byte in a write");
                            end
                            mode <= M_IDLE;
                        end
                    endcase
                end
                else if (mode == M_RX && bcnt == 4'd9)
                begin
                    bcnt     <= '0;
                    sda_pull <= 1'b0;
                    if (to_tx)
                    begin
                        mode     <= M_TX;
                        to_tx    <= 1'b0;
                        sda_pull <= ~tx_sh[7];
                    end
                end
                else if (mode == M_TX && bcnt < 4'd8)
                    sda_pull <= ~tx_sh[7];
                else if (mode == M_TX)
                    sda_pull <= 1'b0;  // ninth clock belongs to the master
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/eeprom_i2c_sva.sv
`default_nettype none

module eeprom_i2c_sva (
    input logic                CLK,
    input logic                RESET,
    input logic                scl,
    input logic                sda_in,
    input logic                cond_pull,
    input eeprom_pkg::wb_req_t wb_req,
    input eeprom_pkg::wb_rsp_t wb_rsp
);
    // with SCL high only the condition generator may move SDA
    sda_stable_a: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && (sda_in != $past(sda_in))) |-> (cond_pull != $past(cond_pull)))
        else $error("SDA changed while SCL high outside a start or stop");

    ack_pulse_a: assert property (@(posedge CLK) disable iff (RESET)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("ack held longer than one cycle");

    ack_in_cycle_a: assert property (@(posedge CLK) disable iff (RESET)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else $error("ack outside a bus cycle");

endmodule

bind eeprom_i2c_top eeprom_i2c_sva sva_i (
    .CLK(CLK), .RESET(RESET), .scl(scl), .sda_in(sda_in),
    .cond_pull(cond_pull), .wb_req(wb_req), .wb_rsp(wb_rsp)
);

`default_nettype wire

// File: tb/eeprom_i2c_tb.sv
`default_nettype none

module eeprom_i2c_tb;
    localparam int SEED       = 32'h7014_79c9;
    localparam int TWR_CYCLES = 300;   // model write cycle lasts several polls
    localparam int N_RAND     = 20;
    localparam int MAX_TXN    = 60;
    localparam int TXN_CYCLES = 1000;  // longest read plus a few retries
    localparam int TIMEOUT    = 16 + MAX_TXN * TXN_CYCLES;

    logic                     CLK;
    logic                     RESET;
    eeprom_pkg::wb_req_t      wb_req;
    eeprom_pkg::wb_rsp_t      wb_rsp;
    logic                     scl;
    logic                     dut_pull;
    logic                     model_pull;
    logic                     sda;
    int                       model_errors;
    int                       errors;
    int                       cycles;
    eeprom_pkg::eeprom_byte_t ref_mem [0:2047];
    eeprom_pkg::eeprom_addr_t adr_q[$];

    assign sda = !(dut_pull || model_pull);  // wired-AND

    eeprom_i2c_top eeprom_i2c_top_i (
        .CLK(CLK), .RESET(RESET), .wb_req(wb_req), .wb_rsp(wb_rsp),
        .scl(scl), .sda_pull(dut_pull), .sda_in(sda)
    );

    eeprom_model #(.TWR(TWR_CYCLES)) model_i (
        .CLK(CLK), .RESET(RESET), .scl(scl), .sda(sda),
        .sda_pull(model_pull), .errors(model_errors)
    );

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    initial
        cycles = 0;

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT)
        begin
            $display("timeout: no ack after %0d cycles", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic check_val(input string name, input int exp_val, input int act_val);
        assert (act_val == exp_val)
        else
        begin
            errors++;
            $display("FAIL %s: expected %02h, actual %02h", name, exp_val, act_val);
        end
    endtask

    task automatic bus_cycle(input logic we, input eeprom_pkg::eeprom_addr_t adr,
                             input eeprom_pkg::eeprom_byte_t dat,
                             output eeprom_pkg::eeprom_byte_t rdat);
        @(negedge CLK);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        do
            @(negedge CLK);
        while (!wb_rsp.ack);
        rdat = wb_rsp.dat;
        @(negedge CLK);  // hold the request through the ack cycle
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
    endtask

    task automatic write_byte(input eeprom_pkg::eeprom_addr_t adr,
                              input eeprom_pkg::eeprom_byte_t dat);
        eeprom_pkg::eeprom_byte_t unused;
        bus_cycle(1'b1, adr, dat, unused);
        ref_mem[adr] = dat;
    endtask

    task automatic read_check(input string name, input eeprom_pkg::eeprom_addr_t adr);
        eeprom_pkg::eeprom_byte_t got;
        bus_cycle(1'b0, adr, 8'h00, got);
        check_val(name, int'(ref_mem[adr]), int'(got));
    endtask

    initial
    begin
        eeprom_pkg::eeprom_addr_t adr;
        eeprom_pkg::eeprom_byte_t dat;
        logic [7:0]               lo;

        void'($urandom(SEED));
        errors   = 0;
        RESET    = 1'b1;
        wb_req   = '0;
        for (int i = 0; i < 2048; i++)
            ref_mem[i] = 8'hFF;
        repeat (16) @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        check_val("reset_ack", 0, int'(wb_rsp.ack));
        check_val("reset_scl", 1, int'(scl));
        check_val("reset_sda_pull", 0, int'(dut_pull));

        adr = eeprom_pkg::eeprom_addr_t'($urandom());
        read_check("unwritten", adr);

        adr = eeprom_pkg::eeprom_addr_t'($urandom());
        dat = eeprom_pkg::eeprom_byte_t'($urandom());
        write_byte(adr, dat);
        read_check("write_then_read", adr);  // lands in the busy window

        lo = 8'($urandom());
        dat = eeprom_pkg::eeprom_byte_t'($urandom());
        write_byte({3'd1, lo}, dat);
        write_byte({3'd6, lo}, ~dat);
        read_check("block_1", {3'd1, lo});
        read_check("block_6", {3'd6, lo});

        for (int i = 0; i < N_RAND; i++)
        begin
            adr = eeprom_pkg::eeprom_addr_t'($urandom());
            dat = eeprom_pkg::eeprom_byte_t'($urandom());
            write_byte(adr, dat);
            adr_q.push_back(adr);
        end
        while (adr_q.size() > 0)
            read_check("random_rw", adr_q.pop_front());

        repeat (20) @(negedge CLK);
        $display("errors: checks %0d, model %0d", errors, model_errors);
        if (errors == 0 && model_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+hdl
hdl/eeprom_pkg.sv
hdl/i2c_scl_gen.sv
hdl/i2c_cond_gen.sv
hdl/i2c_byte_tx.sv
hdl/i2c_byte_rx.sv
hdl/eeprom_ctrl.sv
hdl/eeprom_i2c_top.sv
tb/eeprom_model.sv
tb/eeprom_i2c_sva.sv
tb/eeprom_i2c_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := eeprom_i2c_tb
FILELIST  := filelist.f
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := hdl/eeprom_consts.svh
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
